/* Bender.yml */
package:
  name: cache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pkg_cache.sv
      - hdl/cache_control.sv
      - hdl/cache_datapath.sv
      - hdl/cache.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/cache_chk.sv
      - verification/tb_cache.sv

/* build.f */
+incdir+hdl
hdl/pkg_cache.sv
hdl/cache_control.sv
hdl/cache_datapath.sv
hdl/cache.sv
verification/cache_chk.sv
verification/tb_cache.sv

/* hdl/cache.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache (
    input  logic                     clk,
    input  logic                     rst,

    // CPU port
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic [`CACHE_ADDR_W-1:0] mem_address,
    input  logic [`CACHE_WORD_W-1:0] mem_wdata,
    output logic [`CACHE_WORD_W-1:0] mem_rdata,
    output logic                     mem_resp,

    // Memory port
    output logic                     pmem_read,
    output logic                     pmem_write,
    output logic [`CACHE_ADDR_W-1:0] pmem_address,
    output logic [`CACHE_LINE_W-1:0] pmem_wdata,
    input  logic [`CACHE_LINE_W-1:0] pmem_rdata,
    input  logic                     pmem_resp
);

    pkg_cache::cache_ctrl_t   ctrl;
    pkg_cache::cache_status_t status;

    cache_control u_control (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .status     (status),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ctrl       (ctrl)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .status       (status),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule : cache

/* hdl/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic                     pmem_resp,
    input  pkg_cache::cache_status_t status,
    output logic                     mem_resp,
    output logic                     pmem_read,
    output logic                     pmem_write,
    output pkg_cache::cache_ctrl_t   ctrl
);

    // ######################################################################
    // Control word helpers
    // ######################################################################

    function automatic pkg_cache::cache_ctrl_t ctrl_defaults();
        pkg_cache::cache_ctrl_t c;
        c.ld_valid   = 1'b0;
        c.ld_dirty   = 1'b0;
        c.ld_tag     = 1'b0;
        c.ld_data    = 1'b0;
        c.ld_plru    = 1'b0;
        c.dirty_val  = 1'b0;
        c.dirty_wmux = pkg_cache::W_HIT;
        c.data_wmux  = pkg_cache::W_HIT;
        c.plru_wmux  = pkg_cache::W_HIT;
        c.datamux    = pkg_cache::D_CPU;
        c.pmadmux    = pkg_cache::P_CPU;
        return c;
    endfunction

    function automatic pkg_cache::cache_ctrl_t load_tag_valid(pkg_cache::cache_ctrl_t c);
        c.ld_tag   = 1'b1;
        c.ld_valid = 1'b1;
        return c;
    endfunction

    function automatic pkg_cache::cache_ctrl_t load_data(pkg_cache::cache_ctrl_t c,
                                                         pkg_cache::waymux_t way,
                                                         pkg_cache::datamux_t src);
        c.ld_data   = 1'b1;
        c.data_wmux = way;
        c.datamux   = src;
        return c;
    endfunction

    function automatic pkg_cache::cache_ctrl_t load_dirty(pkg_cache::cache_ctrl_t c,
                                                          pkg_cache::waymux_t way,
                                                          logic val);
        c.ld_dirty   = 1'b1;
        c.dirty_wmux = way;
        c.dirty_val  = val;
        return c;
    endfunction

    function automatic pkg_cache::cache_ctrl_t load_plru(pkg_cache::cache_ctrl_t c,
                                                         pkg_cache::waymux_t way);
        c.ld_plru   = 1'b1;
        c.plru_wmux = way;
        return c;
    endfunction

    function automatic pkg_cache::cache_ctrl_t set_pmem_addr(pkg_cache::cache_ctrl_t c,
                                                             pkg_cache::pmadmux_t sel);
        c.pmadmux = sel;
        return c;
    endfunction

    // ######################################################################
    // State machine
    // ######################################################################

    pkg_cache::cache_state_t state;
    pkg_cache::cache_state_t next_state;
    logic                    req;

    assign req = mem_read || mem_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pkg_cache::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        ctrl       = ctrl_defaults();
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        next_state = state;
        case (state)
            pkg_cache::IDLE: begin
                if (req) begin
                    next_state = pkg_cache::CMP;
                end
            end
            pkg_cache::CMP: begin
                if (!req) begin
                    next_state = pkg_cache::IDLE;  // Requester withdrew
                end else if (status.hit) begin
                    if (mem_write) begin
                        ctrl = load_data(ctrl, pkg_cache::W_HIT, pkg_cache::D_CPU);
                        ctrl = load_dirty(ctrl, pkg_cache::W_HIT, 1'b1);
                    end
                    ctrl       = load_plru(ctrl, pkg_cache::W_HIT);
                    mem_resp   = 1'b1;
                    next_state = pkg_cache::IDLE;
                end else if (status.victim_dirty) begin
                    next_state = pkg_cache::EVICT;
                end else begin
                    next_state = pkg_cache::LOAD;
                end
            end
            pkg_cache::EVICT: begin
                ctrl       = set_pmem_addr(ctrl, pkg_cache::P_CACHE);
                pmem_write = 1'b1;
                if (pmem_resp) begin
                    next_state = pkg_cache::LOAD;
                end
            end
            pkg_cache::LOAD: begin
                ctrl      = set_pmem_addr(ctrl, pkg_cache::P_CPU);
                pmem_read = 1'b1;
                if (pmem_resp) begin  // Fill only when the line is on the bus
                    ctrl       = load_tag_valid(ctrl);
                    ctrl       = load_data(ctrl, pkg_cache::W_LRU, pkg_cache::D_LLC);
                    ctrl       = load_dirty(ctrl, pkg_cache::W_LRU, 1'b0);
                    next_state = pkg_cache::CMP;
                end
            end
            default: begin
                next_state = pkg_cache::IDLE;
            end
        endcase
    end

endmodule : cache_control

/* hdl/cache_datapath.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  pkg_cache::cache_ctrl_t   ctrl,
    input  logic [`CACHE_ADDR_W-1:0] mem_address,
    input  logic [`CACHE_WORD_W-1:0] mem_wdata,
    input  logic [`CACHE_LINE_W-1:0] pmem_rdata,
    output pkg_cache::cache_status_t status,
    output logic [`CACHE_WORD_W-1:0] mem_rdata,
    output logic [`CACHE_ADDR_W-1:0] pmem_address,
    output logic [`CACHE_LINE_W-1:0] pmem_wdata
);

    localparam int NUM_SETS  = 1 << `CACHE_SET_BITS;
    localparam int BYTE_BITS = $clog2(`CACHE_WORD_W / 8);
    localparam int WSEL_W    = `CACHE_OFFSET_BITS - BYTE_BITS;  // Word within line

    // ######################################################################
    // Address split
    // ######################################################################

    logic [`CACHE_TAG_W-1:0]    addr_tag;
    logic [`CACHE_SET_BITS-1:0] addr_set;
    logic [WSEL_W-1:0]          addr_word;

    assign addr_tag  = mem_address[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign addr_set  = mem_address[`CACHE_OFFSET_BITS +: `CACHE_SET_BITS];
    assign addr_word = mem_address[BYTE_BITS +: WSEL_W];

    // ######################################################################
    // Arrays
    // ######################################################################

    logic [1:0][NUM_SETS-1:0] valid_arr;
    logic [1:0][NUM_SETS-1:0] dirty_arr;
    logic [NUM_SETS-1:0]      lru_arr;                  // Names the LRU way of each set
    logic [`CACHE_TAG_W-1:0]  tag_arr  [2][NUM_SETS];
    logic [`CACHE_LINE_W-1:0] data_arr [2][NUM_SETS];

    // ######################################################################
    // Lookup
    // ######################################################################

    logic [1:0]               way_hit;
    logic                     hit_way;
    logic                     lru_way;
    logic                     dirty_way;
    logic                     data_way;
    logic                     plru_way;
    logic [`CACHE_TAG_W-1:0]  victim_tag;
    logic [`CACHE_LINE_W-1:0] hit_line;
    logic [`CACHE_LINE_W-1:0] victim_line;
    logic [`CACHE_LINE_W-1:0] merged_line;
    logic [`CACHE_LINE_W-1:0] line_in;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_arr[w][addr_set] && (tag_arr[w][addr_set] == addr_tag);
        end
    end

    assign hit_way = way_hit[1];  // Both ways never match one tag
    assign lru_way = lru_arr[addr_set];

    assign status.hit          = |way_hit;
    assign status.victim_dirty = dirty_arr[lru_way][addr_set];

    // Way selectors
    assign dirty_way = (ctrl.dirty_wmux == pkg_cache::W_HIT) ? hit_way : lru_way;
    assign data_way  = (ctrl.data_wmux == pkg_cache::W_HIT) ? hit_way : lru_way;
    assign plru_way  = (ctrl.plru_wmux == pkg_cache::W_HIT) ? hit_way : lru_way;

    assign hit_line    = data_arr[hit_way][addr_set];
    assign victim_line = data_arr[lru_way][addr_set];
    assign victim_tag  = tag_arr[lru_way][addr_set];

    assign mem_rdata = hit_line[addr_word*`CACHE_WORD_W +: `CACHE_WORD_W];

    // ######################################################################
    // Line merge and memory side
    // ######################################################################

    always_comb begin
        merged_line = hit_line;
        merged_line[addr_word*`CACHE_WORD_W +: `CACHE_WORD_W] = mem_wdata;
    end

    assign line_in = (ctrl.datamux == pkg_cache::D_LLC) ? pmem_rdata : merged_line;

    assign pmem_wdata   = victim_line;
    assign pmem_address = (ctrl.pmadmux == pkg_cache::P_CACHE)
                        ? {victim_tag, addr_set, {`CACHE_OFFSET_BITS{1'b0}}}
                        : {addr_tag, addr_set, {`CACHE_OFFSET_BITS{1'b0}}};

    // ######################################################################
    // Array updates
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
            dirty_arr <= '0;
            lru_arr   <= '0;
        end else begin
            if (ctrl.ld_valid) begin
                valid_arr[data_way][addr_set] <= 1'b1;  // Filled with the data
            end
            if (ctrl.ld_dirty) begin
                dirty_arr[dirty_way][addr_set] <= ctrl.dirty_val;
            end
            if (ctrl.ld_plru) begin
                lru_arr[addr_set] <= ~plru_way;  // Other way becomes LRU
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ld_tag) begin
            tag_arr[data_way][addr_set] <= addr_tag;
        end
        if (ctrl.ld_data) begin
            data_arr[data_way][addr_set] <= line_in;
        end
    end

endmodule : cache_datapath

/* hdl/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ######################################################################
// CPU side
// ######################################################################

`define CACHE_ADDR_W 32       // Byte address
`define CACHE_WORD_W 32

// ######################################################################
// Line and set geometry
// ######################################################################

`define CACHE_LINE_W 128      // Four words per line
`define CACHE_OFFSET_BITS 4
`define CACHE_SET_BITS 3      // Eight sets

`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_SET_BITS - `CACHE_OFFSET_BITS)

`endif

/* hdl/pkg_cache.sv */
package pkg_cache;

    // ######################################################################
    // Controller state and datapath selectors
    // ######################################################################

    typedef enum logic [1:0] {
        IDLE,
        CMP,
        EVICT,
        LOAD
    } cache_state_t;

    typedef enum logic {
        W_HIT,                // Way that matched the tag
        W_LRU                 // Replacement victim
    } waymux_t;

    typedef enum logic {
        D_CPU,                // Hit line with CPU word merged in
        D_LLC                 // Whole line from memory
    } datamux_t;

    typedef enum logic {
        P_CPU,
        P_CACHE               // Stored victim tag
    } pmadmux_t;

    // ######################################################################
    // Control and status bundles
    // ######################################################################

    typedef struct packed {
        logic     ld_valid;
        logic     ld_dirty;
        logic     ld_tag;
        logic     ld_data;
        logic     ld_plru;
        logic     dirty_val;
        waymux_t  dirty_wmux;
        waymux_t  data_wmux;   // Also steers tag and valid writes
        waymux_t  plru_wmux;
        datamux_t datamux;
        pmadmux_t pmadmux;
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } cache_status_t;

endpackage : pkg_cache

/* verification/cache_chk.sv */
`timescale 1ns/1ps

module cache_chk (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    int unsigned fail_count = 0;  // Assertion failures so far

    // ######################################################################
    // Memory port strobes
    // ######################################################################

    strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else begin
            fail_count++;
            $error("pmem_read and pmem_write high together");
        end

    read_held: assert property (@(posedge clk) disable iff (rst)
        pmem_read && !pmem_resp |=> pmem_read)
        else begin
            fail_count++;
            $error("pmem_read dropped before pmem_resp");
        end

    write_held: assert property (@(posedge clk) disable iff (rst)
        pmem_write && !pmem_resp |=> pmem_write)
        else begin
            fail_count++;
            $error("pmem_write dropped before pmem_resp");
        end

    // ######################################################################
    // CPU response and reset
    // ######################################################################

    resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read || mem_write))
        else begin
            fail_count++;
            $error("mem_resp without a request");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !mem_resp && !pmem_read && !pmem_write)
        else begin
            fail_count++;
            $error("Strobe high in the cycle after reset");
        end

endmodule : cache_chk

bind cache_control cache_chk chk (
    .clk        (clk),
    .rst        (rst),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write),
    .pmem_resp  (pmem_resp)
);

/* verification/tb_cache.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_cache;

    localparam int                      TIMEOUT  = 200;
    localparam int                      NUM_TXN  = 400;
    localparam logic [31:0]             SEED     = 32'h1f75ac45;
    localparam logic [`CACHE_TAG_W-3:0] TAG_HI   = 23'h51a2c3;   // Fixed upper tag bits
    localparam logic [13:0]             LRU_TAGS = {2'd2, 2'd1, 2'd0, 2'd2, 2'd0, 2'd1, 2'd0};
    localparam logic [6:0]              LRU_HITS = 7'b0010100;   // Only the A touches hit

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     mem_read;
    logic                     mem_write;
    logic                     mem_resp;
    logic                     pmem_read;
    logic                     pmem_write;
    logic                     pmem_resp;
    logic [`CACHE_ADDR_W-1:0] mem_address;
    logic [`CACHE_ADDR_W-1:0] pmem_address;
    logic [`CACHE_WORD_W-1:0] mem_wdata;
    logic [`CACHE_WORD_W-1:0] mem_rdata;
    logic [`CACHE_LINE_W-1:0] pmem_wdata;
    logic [`CACHE_LINE_W-1:0] pmem_rdata;

    logic [31:0]              lfsr_state;
    logic [`CACHE_LINE_W-1:0] backing_mem [32];  // Index is {tag, set}
    logic [`CACHE_WORD_W-1:0] arch_mem [128];
    logic                     sh_valid [2][8];
    logic                     sh_dirty [2][8];
    logic [1:0]               sh_tag [2][8];
    logic                     sh_lru [8];
    logic                     was_hit;
    logic [31:0]              rnd_op;
    logic [31:0]              rnd_data;

    always #5 clk = ~clk;

    cache DUT (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    // ######################################################################
    // Random numbers, addresses, checks
    // ######################################################################

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r[i]       = lfsr_state[0];
        end
        return r;
    endfunction

    function automatic logic [`CACHE_ADDR_W-1:0] line_addr(logic [1:0] t, logic [2:0] s);
        return {TAG_HI, t, s, 4'h0};
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Cache testbench stopped at the first error");
    endtask

    task automatic check_word(logic [`CACHE_WORD_W-1:0] got, exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(logic [`CACHE_LINE_W-1:0] got, exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(logic [`CACHE_ADDR_W-1:0] got, exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(logic got, exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ######################################################################
    // One CPU access with the memory responder and the shadow cache
    // ######################################################################

    task automatic run_access(input logic is_write, input logic [1:0] t, input logic [2:0] s,
                              input logic [1:0] w, input logic [31:0] wdata,
                              output logic hit);
        logic                     pred_hit;
        logic                     way;
        logic                     wb;
        logic                     busy;
        logic                     busy_wr;
        logic                     done;
        logic                     resp_s;
        logic                     rd_s;
        logic                     wr_s;
        logic [1:0]               vtag;
        logic [`CACHE_LINE_W-1:0] wb_line;
        int                       n_ops;
        int                       op_idx;
        int                       countdown;
        int                       cycles;

        pred_hit = 1'b0;
        way      = sh_lru[s];
        for (int k = 0; k < 2; k++) begin
            if (sh_valid[k][s] && sh_tag[k][s] == t) begin
                pred_hit = 1'b1;
                way      = k[0];
            end
        end
        wb    = !pred_hit && sh_valid[way][s] && sh_dirty[way][s];
        vtag  = sh_tag[way][s];
        n_ops = pred_hit ? 0 : (wb ? 2 : 1);
        for (int k = 0; k < 4; k++) begin
            wb_line[k*32 +: 32] = arch_mem[{vtag, s}*4 + k];
        end

        mem_address = line_addr(t, s) | {w, 2'b00};
        mem_wdata   = wdata;
        mem_read    = !is_write;
        mem_write   = is_write;
        busy        = 1'b0;
        busy_wr     = 1'b0;
        done        = 1'b0;
        op_idx      = 0;
        countdown   = 0;
        cycles      = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: the cache did not answer within %0d cycles", TIMEOUT);
                abort_run();
            end
            resp_s    = mem_resp;
            rd_s      = pmem_read;
            wr_s      = pmem_write;
            pmem_resp = 1'b0;                      // One-cycle pulse
            check_flag(rd_s && wr_s, 1'b0, "pmem_read and pmem_write together");
            if (resp_s) begin
                check_flag(op_idx == n_ops && !busy, 1'b1, "memory transfers before mem_resp");
                if (pred_hit) begin
                    check_flag(cycles == 1, 1'b1, "hit answered at the second edge");
                end
                if (!is_write) begin
                    check_word(mem_rdata, arch_mem[{t, s}*4 + w], "read data");
                end
                done = 1'b1;
            end else begin
                if (!busy && (rd_s || wr_s)) begin
                    if (op_idx >= n_ops) begin
                        $display("Unexpected memory request at %0t ns", $time);
                        abort_run();
                    end
                    busy_wr = wb && op_idx == 0;  // Write-back goes first
                    check_flag(wr_s, busy_wr, "pmem_write for this transfer");
                    if (busy_wr) begin
                        check_addr(pmem_address, line_addr(vtag, s), "write-back address");
                        check_line(pmem_wdata, wb_line, "write-back line");
                        backing_mem[{vtag, s}] = pmem_wdata;
                    end else begin
                        check_addr(pmem_address, line_addr(t, s), "fill address");
                    end
                    busy      = 1'b1;
                    countdown = rand_bits(2) + 1;
                end
                if (busy) begin
                    check_flag(busy_wr ? wr_s : rd_s, 1'b1, "memory strobe held");
                    countdown--;
                    if (countdown == 0) begin
                        if (!busy_wr) begin
                            pmem_rdata = backing_mem[{t, s}];
                        end
                        pmem_resp = 1'b1;
                        busy      = 1'b0;
                        op_idx++;
                    end
                end
            end
        end

        if (!pred_hit) begin
            sh_valid[way][s] = 1'b1;
            sh_tag[way][s]   = t;
            sh_dirty[way][s] = 1'b0;
        end
        sh_lru[s] = ~way;
        if (is_write) begin
            sh_dirty[way][s]       = 1'b1;
            arch_mem[{t, s}*4 + w] = wdata;
        end
        hit = (cycles == 1) && (op_idx == 0);

        @(negedge clk);                           // Hold past the response edge
        check_flag(mem_resp, 1'b0, "mem_resp longer than one cycle");
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    // ######################################################################
    // Test sequence
    // ######################################################################

    initial begin
        lfsr_state  = SEED;
        rst         = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        pmem_rdata  = '0;
        pmem_resp   = 1'b0;
        for (int l = 0; l < 32; l++) begin
            for (int k = 0; k < 4; k++) begin
                backing_mem[l][k*32 +: 32] = rand_bits(32);
                arch_mem[l*4 + k]          = backing_mem[l][k*32 +: 32];
            end
        end
        for (int s = 0; s < 8; s++) begin
            sh_lru[s] = 1'b0;
            for (int k = 0; k < 2; k++) begin
                sh_valid[k][s] = 1'b0;
                sh_dirty[k][s] = 1'b0;
                sh_tag[k][s]   = 2'd0;
            end
        end

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(mem_resp, 1'b0, "mem_resp after reset");
        check_flag(pmem_read, 1'b0, "pmem_read after reset");
        check_flag(pmem_write, 1'b0, "pmem_write after reset");

        // A B A C A B C in set 5, C written
        for (int i = 0; i < 7; i++) begin
            run_access(i == 3, LRU_TAGS[i*2 +: 2], 3'd5, 2'd1, 32'hc0de_0000 + i, was_hit);
            check_flag(was_hit, LRU_HITS[i], "hit or miss in the LRU sequence");
        end

        for (int n = 0; n < NUM_TXN; n++) begin
            rnd_op   = rand_bits(8);                 // Write, tag, set and word bits
            rnd_data = rand_bits(32);
            run_access(rnd_op[0], rnd_op[2:1], rnd_op[5:3], rnd_op[7:6], rnd_data, was_hit);
        end

        if (DUT.u_control.chk.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Controller assertions failed %0d times", DUT.u_control.chk.fail_count);
            abort_run();
        end
    end

endmodule : tb_cache
